/* transmit_top.f */
+incdir+hw
hw/tx_pkg.sv
hw/tx_config_regs.sv
hw/awg_player.sv
hw/triangle_gen.sv
hw/channel_mux.sv
hw/dac_prescaler.sv
hw/transmit_top.sv
verification/transmit_top_tb.sv

/* Bender.yml */
package:
  name: transmit_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/tx_pkg.sv
      - hw/tx_config_regs.sv
      - hw/awg_player.sv
      - hw/triangle_gen.sv
      - hw/channel_mux.sv
      - hw/dac_prescaler.sv
      - hw/transmit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/transmit_top_tb.sv

/* verification/transmit_top_tb.sv */
/*
 transmit path testbench: register writes, a cycle-level reference model
 of the sources and prescaler, and assertion checks on the DAC frame
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module transmit_top_tb;

  import tx_pkg::*;

  localparam int PH_IDLE  = 0;
  localparam int PH_RUN   = 1;
  localparam int PH_TRI   = 2;
  localparam int PH_SHARE = 3;
  localparam int PH_STOP  = 4;
  localparam int PH_DONE  = 5;

  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 20;
  localparam int PLAY_CYCLES   = 64;
  localparam int TRI_CYCLES    = 700;
  localparam int STOP_CYCLES   = 40;
  localparam int SETTLE_CYCLES = 8;
  localparam int NUM_WRITES    = 60;
  localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + IDLE_CYCLES + 3 * PLAY_CYCLES +
                                       TRI_CYCLES + STOP_CYCLES + 2 * NUM_WRITES +
                                       8 * SETTLE_CYCLES);

  // Q2.16 scales
  localparam logic [17:0] SCALE_ONE  = 18'h10000;
  localparam logic [17:0] SCALE_HALF = 18'h08000;
  localparam logic [17:0] SCALE_1P75 = 18'h1C000;
  localparam int          STOP_OFFSET = -37;

  logic       ps_clk;
  logic       arst_n;
  logic       cfg_we;
  logic [7:0] cfg_addr;
  cfg_word_u  cfg_data;
  frame_t     dac_frame;

  logic        checks_on;
  int          phase;
  int          value_errors;
  int          rule_errors;
  int          cycle_count;
  logic [31:0] lcg_state;

  // reference model state
  logic [1:0]  m_sel [`TX_CHANNELS];
  scale_t      m_scale [`TX_CHANNELS];
  offset_t     m_offset [`TX_CHANNELS];
  logic [31:0] m_inc [`TX_CHANNELS];
  logic [4:0]  m_depth [`TX_CHANNELS];
  data_t       m_mem [`TX_CHANNELS][`TX_AWG_DEPTH];
  int          m_idx [`TX_CHANNELS];
  logic [31:0] m_acc [`TX_CHANNELS];
  logic        m_wrap [`TX_CHANNELS];
  logic        m_start;
  logic        m_stop;
  logic        m_play;
  sample_t     m_src [`TX_SOURCES];
  sample_t     m_pipe [`TX_CHANNELS][3];
  sample_t     exp_out [`TX_CHANNELS];

  transmit_top UUT (
    .ps_clk      (ps_clk),
    .arst_n_i    (arst_n),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_data_i  (cfg_data),
    .dac_frame_o (dac_frame)
  );

  always #5 ps_clk = ~ps_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int frame_len(input logic [4:0] depth);
    return (depth == 5'd0) ? 1 : int'(depth);
  endfunction

  // rising half from most negative, falling half from most positive
  function automatic data_t tri_fold(input logic [31:0] acc);
    int ramp;
    ramp = int'(acc[30:15]);
    if (!acc[31]) begin
      return data_t'(ramp - 32768);
    end
    return data_t'(32767 - ramp);
  endfunction

  function automatic sample_t apply_prescale(input sample_t s, input scale_t scale,
                                             input offset_t offset);
    longint  prod;
    longint  level;
    sample_t r;
    prod  = longint'(s.data) * longint'(scale);
    level = (prod >>> `TX_SCALE_FRAC_BITS) + longint'(offset);
    if (level > 32767) begin
      level = 32767;
    end else if (level < -32768) begin
      level = -32768;
    end
    r.trigger = s.trigger;
    r.data    = data_t'(level);
    return r;
  endfunction

  function automatic logic [31:0] scale_offset_word(input logic [17:0] s, input logic [13:0] o);
    return {s, o};
  endfunction

  task automatic report_value(input string name, input int ch, input int exp_v, input int act_v);
    value_errors++;
    $display("FAILED t=%0t %s[%0d] expected %0d actual %0d", $time, name, ch, exp_v, act_v);
  endtask

  task automatic report_rule(input string what);
    rule_errors++;
    $display("t=%0t %s", $time, what);
  endtask

  task automatic cfg_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge ps_clk);
    cfg_we   <= 1'b1;
    cfg_addr <= addr;
    cfg_data <= data;
    @(posedge ps_clk);
    cfg_we   <= 1'b0;
  endtask

  // full-scale values at indices 2 and 3 so both limits get exercised
  task automatic fill_awg_memory();
    logic [15:0] s;
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      for (int i = 0; i < `TX_AWG_DEPTH; i++) begin
        lcg_state = lcg_next(lcg_state);
        s = lcg_state[31:16];
        if (i == 2) begin
          s = 16'h7fff;
        end else if (i == 3) begin
          s = 16'h8000;
        end
        cfg_write(`TX_ADDR_AWG_MEM + ch * `TX_AWG_DEPTH + i, {16'h0, s});
      end
    end
  endtask

  task automatic set_scales(input logic [17:0] s0, input logic [17:0] s1, input int off);
    cfg_write(`TX_ADDR_SCALE_OFFSET + 0, scale_offset_word(s0, off));
    cfg_write(`TX_ADDR_SCALE_OFFSET + 1, scale_offset_word(s1, off));
  endtask

  // model: sources one cycle after their state, then mux and two prescaler stages
  always @(posedge ps_clk or negedge arst_n) begin : b_model
    int                      wch;
    int                      idx;
    logic [`TX_PHASE_BITS:0] acc_sum;
    if (!arst_n) begin
      m_start <= 1'b0;
      m_stop  <= 1'b0;
      m_play  <= 1'b0;
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        m_sel[ch]    <= '0;
        m_scale[ch]  <= '0;
        m_offset[ch] <= '0;
        m_inc[ch]    <= '0;
        m_depth[ch]  <= '0;
        m_idx[ch]    <= 0;
        m_acc[ch]    <= '0;
        m_wrap[ch]   <= 1'b0;
        for (int k = 0; k < 3; k++) begin
          m_pipe[ch][k] <= '0;
        end
      end
      for (int s = 0; s < `TX_SOURCES; s++) begin
        m_src[s] <= '0;
      end
    end else begin
      wch = int'(cfg_addr[3:0]);
      if (cfg_we && wch < `TX_CHANNELS) begin
        case (cfg_addr & 8'hf0)
          `TX_ADDR_MUX_SEL: m_sel[wch] <= cfg_data.mux.sel;
          `TX_ADDR_SCALE_OFFSET: begin
            m_scale[wch]  <= cfg_data.scale_offset.scale;
            m_offset[wch] <= cfg_data.scale_offset.offset;
          end
          `TX_ADDR_TRI_INC: m_inc[wch] <= cfg_data.phase_inc;
          `TX_ADDR_AWG_DEPTH: m_depth[wch] <= cfg_data[4:0];
          default: ;
        endcase
      end
      if (cfg_we && cfg_addr >= `TX_ADDR_AWG_MEM) begin
        m_mem[cfg_addr[4]][cfg_addr[3:0]] <= cfg_data.awg.sample;
      end
      m_start <= cfg_we && cfg_addr == `TX_ADDR_AWG_CTRL && cfg_data[0];
      m_stop  <= cfg_we && cfg_addr == `TX_ADDR_AWG_CTRL && cfg_data[1];
      if (m_stop) begin
        m_play <= 1'b0;
      end else if (m_start) begin
        m_play <= 1'b1;
      end
      for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
        if (m_stop) begin
          m_src[ch] <= '0;
          m_idx[ch] <= 0;
        end else if (m_start || m_play) begin
          idx = m_start ? 0 : m_idx[ch];
          m_src[ch].trigger <= (idx == 0);
          m_src[ch].data    <= m_mem[ch][idx];
          m_idx[ch]         <= (idx + 1 >= frame_len(m_depth[ch])) ? 0 : idx + 1;
        end
        acc_sum = {1'b0, m_acc[ch]} + {1'b0, m_inc[ch]};
        m_acc[ch]  <= acc_sum[`TX_PHASE_BITS-1:0];
        m_wrap[ch] <= acc_sum[`TX_PHASE_BITS];
        m_src[`TX_CHANNELS + ch].trigger <= m_wrap[ch];
        m_src[`TX_CHANNELS + ch].data    <= tri_fold(m_acc[ch]);
        m_pipe[ch][0] <= m_src[m_sel[ch]];
        m_pipe[ch][1] <= m_pipe[ch][0];
        m_pipe[ch][2] <= m_pipe[ch][1];
      end
    end
  end

  always_comb begin
    for (int ch = 0; ch < `TX_CHANNELS; ch++) begin
      exp_out[ch] = apply_prescale(m_pipe[ch][2], m_scale[ch], m_offset[ch]);
    end
  end

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_check
    a_data: assert property (@(posedge ps_clk) disable iff (!arst_n || !checks_on)
      dac_frame[ch].data == exp_out[ch].data)
      else report_value("dac_frame_o.data", ch, $sampled(exp_out[ch].data),
                        $sampled(dac_frame[ch].data));

    a_trig: assert property (@(posedge ps_clk) disable iff (!arst_n || !checks_on)
      dac_frame[ch].trigger == exp_out[ch].trigger)
      else report_value("dac_frame_o.trigger", ch, $sampled(exp_out[ch].trigger),
                        $sampled(dac_frame[ch].trigger));

    a_idle: assert property (@(posedge ps_clk) disable iff (!arst_n || phase != PH_IDLE)
      dac_frame[ch] == '0)
      else report_value("dac_frame_o", ch, 0, $sampled(dac_frame[ch]));

    a_tri_period: assert property (@(posedge ps_clk) disable iff (phase != PH_TRI)
      dac_frame[ch].trigger |-> ##256 dac_frame[ch].trigger)
      else report_rule("triangle trigger missing 256 cycles after the previous one");

    // the peak and the wrap sample are the two turning points
    a_tri_step: assert property (@(posedge ps_clk) disable iff (phase != PH_TRI)
      (!dac_frame[ch].trigger && dac_frame[ch].data != 16'sh7fff) |->
        (dac_frame[ch].data - $past(dac_frame[ch].data) == 512 ||
         $past(dac_frame[ch].data) - dac_frame[ch].data == 512))
      else report_rule("triangle step between samples is not 512");

    a_tri_fall: assert property (@(posedge ps_clk) disable iff (phase != PH_TRI)
      dac_frame[ch].data == 16'sh7fff |=> dac_frame[ch].data < $past(dac_frame[ch].data))
      else report_rule("triangle does not fall after the midpoint");

    a_tri_rise: assert property (@(posedge ps_clk) disable iff (phase != PH_TRI)
      dac_frame[ch].trigger |=> dac_frame[ch].data > $past(dac_frame[ch].data))
      else report_rule("triangle does not rise after the period start");

    a_stopped: assert property (@(posedge ps_clk) disable iff (phase != PH_STOP)
      dac_frame[ch].data == STOP_OFFSET && !dac_frame[ch].trigger)
      else report_value("dac_frame_o", ch, STOP_OFFSET, $sampled(dac_frame[ch]));
  end

  a_share: assert property (@(posedge ps_clk) disable iff (phase != PH_SHARE)
    dac_frame[1] == dac_frame[0])
    else report_value("dac_frame_o", 1, $sampled(dac_frame[0]), $sampled(dac_frame[1]));

  initial begin
    ps_clk       = 1'b0;
    arst_n       = 1'b0;
    cfg_we       = 1'b0;
    cfg_addr     = '0;
    cfg_data     = '0;
    checks_on    = 1'b0;
    phase        = PH_IDLE;
    value_errors = 0;
    rule_errors  = 0;
    lcg_state    = 32'd40308;
    repeat (RESET_CYCLES) @(posedge ps_clk);
    arst_n    <= 1'b1;
    checks_on <= 1'b1;
    repeat (IDLE_CYCLES) @(posedge ps_clk);

    // looping AWG frames of 16 and 5 samples at unity gain
    checks_on <= 1'b0;
    phase     <= PH_RUN;
    fill_awg_memory();
    cfg_write(`TX_ADDR_AWG_DEPTH + 0, 32'd16);
    cfg_write(`TX_ADDR_AWG_DEPTH + 1, 32'd5);
    set_scales(SCALE_ONE, SCALE_ONE, 0);
    cfg_write(`TX_ADDR_MUX_SEL + 0, 32'd0);
    cfg_write(`TX_ADDR_MUX_SEL + 1, 32'd1);
    cfg_write(`TX_ADDR_AWG_CTRL, 32'h1);
    checks_on <= 1'b1;
    repeat (PLAY_CYCLES) @(posedge ps_clk);

    // half scale on channel 0, 1.75 on channel 1 clips both ways
    checks_on <= 1'b0;
    set_scales(SCALE_HALF, SCALE_1P75, 100);
    repeat (SETTLE_CYCLES) @(posedge ps_clk);
    checks_on <= 1'b1;
    repeat (PLAY_CYCLES) @(posedge ps_clk);

    checks_on <= 1'b0;
    cfg_write(`TX_ADDR_TRI_INC + 0, 32'h0100_0000);
    cfg_write(`TX_ADDR_TRI_INC + 1, 32'h0100_0000);
    set_scales(SCALE_ONE, SCALE_ONE, 0);
    cfg_write(`TX_ADDR_MUX_SEL + 0, 32'd2);
    cfg_write(`TX_ADDR_MUX_SEL + 1, 32'd3);
    repeat (SETTLE_CYCLES) @(posedge ps_clk);
    checks_on <= 1'b1;
    phase     <= PH_TRI;
    repeat (TRI_CYCLES) @(posedge ps_clk);

    // channel 1 follows channel 0's AWG
    checks_on <= 1'b0;
    phase     <= PH_RUN;
    cfg_write(`TX_ADDR_MUX_SEL + 0, 32'd0);
    cfg_write(`TX_ADDR_MUX_SEL + 1, 32'd0);
    repeat (SETTLE_CYCLES) @(posedge ps_clk);
    checks_on <= 1'b1;
    phase     <= PH_SHARE;
    repeat (PLAY_CYCLES) @(posedge ps_clk);

    checks_on <= 1'b0;
    phase     <= PH_RUN;
    cfg_write(`TX_ADDR_MUX_SEL + 1, 32'd1);
    set_scales(SCALE_ONE, SCALE_ONE, STOP_OFFSET);
    repeat (SETTLE_CYCLES) @(posedge ps_clk);
    checks_on <= 1'b1;
    cfg_write(`TX_ADDR_AWG_CTRL, 32'h2);
    repeat (SETTLE_CYCLES) @(posedge ps_clk);
    phase <= PH_STOP;
    repeat (STOP_CYCLES) @(posedge ps_clk);

    checks_on <= 1'b0;
    phase     <= PH_DONE;
    @(posedge ps_clk);
    $display("errors: value %0d, rule %0d", value_errors, rule_errors);
    if (value_errors + rule_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge ps_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  initial cycle_count = 0;

endmodule

/* hw/transmit_top.sv */
/*
 transmit path top level connecting the configuration registers, AWG and
 triangle sources, channel crossbar and DAC prescaler
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module transmit_top (
  input  logic              ps_clk,
  input  logic              arst_n_i,
  input  logic              cfg_we_i,
  input  logic [7:0]        cfg_addr_i,
  input  tx_pkg::cfg_word_u cfg_data_i,
  output tx_pkg::frame_t    dac_frame_o
);

  import tx_pkg::*;

  cfg_t   cfg;
  frame_t awg_frame;
  frame_t tri_frame;
  frame_t mux_frame;

  logic                         mem_we;
  logic [`TX_CHAN_BITS-1:0]     mem_chan;
  logic [`TX_AWG_IDX_BITS-1:0]  mem_idx;
  data_t                        mem_data;
  logic                         awg_start;
  logic                         awg_stop;

  tx_config_regs u_regs (
    .ps_clk      (ps_clk),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_data_i  (cfg_data_i),
    .cfg_o       (cfg),
    .mem_we_o    (mem_we),
    .mem_chan_o  (mem_chan),
    .mem_idx_o   (mem_idx),
    .mem_data_o  (mem_data),
    .awg_start_o (awg_start),
    .awg_stop_o  (awg_stop)
  );

  awg_player u_awg (
    .ps_clk     (ps_clk),
    .arst_n_i   (arst_n_i),
    .depth_i    (cfg.awg_depth),
    .mem_we_i   (mem_we),
    .mem_chan_i (mem_chan),
    .mem_idx_i  (mem_idx),
    .mem_data_i (mem_data),
    .start_i    (awg_start),
    .stop_i     (awg_stop),
    .awg_o      (awg_frame)
  );

  triangle_gen u_tri (
    .ps_clk      (ps_clk),
    .arst_n_i    (arst_n_i),
    .phase_inc_i (cfg.tri_inc),
    .tri_o       (tri_frame)
  );

  channel_mux u_mux (
    .ps_clk   (ps_clk),
    .arst_n_i (arst_n_i),
    .sel_i    (cfg.mux_sel),
    .awg_i    (awg_frame),
    .tri_i    (tri_frame),
    .mux_o    (mux_frame)
  );

  dac_prescaler u_prescale (
    .ps_clk      (ps_clk),
    .arst_n_i    (arst_n_i),
    .scale_i     (cfg.scale),
    .offset_i    (cfg.offset),
    .data_i      (mux_frame),
    .dac_frame_o (dac_frame_o)
  );

endmodule

/* hw/dac_prescaler.sv */
/*
 DAC prescaler: signed Q2.16 scale, offset add and saturation to the DAC
 range in two pipeline stages, trigger delayed alongside
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module dac_prescaler (
  input  logic                                 ps_clk,
  input  logic                                 arst_n_i,
  input  tx_pkg::scale_t [`TX_CHANNELS-1:0]    scale_i,
  input  tx_pkg::offset_t [`TX_CHANNELS-1:0]   offset_i,
  input  tx_pkg::frame_t                       data_i,
  output tx_pkg::frame_t                       dac_frame_o
);

  import tx_pkg::*;

  localparam int SW   = `TX_SAMPLE_WIDTH;
  localparam int FRAC = `TX_SCALE_FRAC_BITS;
  localparam int PW   = `TX_SAMPLE_WIDTH + `TX_SCALE_WIDTH;
  localparam int IW   = PW - FRAC;
  localparam int SUMW = IW + 1;

  localparam logic signed [SUMW-1:0] SAT_MAX = (2 ** (SW - 1)) - 1;
  localparam logic signed [SUMW-1:0] SAT_MIN = -(2 ** (SW - 1));

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    logic signed [PW-1:0]   prod_q;
    logic                   trig_q;
    logic signed [IW-1:0]   prod_int;
    logic signed [SUMW-1:0] sum;
    data_t                  sat;
    sample_t                out_q;

    // truncate the fraction bits
    assign prod_int = prod_q[PW-1:FRAC];
    assign sum      = prod_int + offset_i[ch];

    always_comb begin
      if (sum > SAT_MAX) begin
        sat = SAT_MAX[SW-1:0];
      end else if (sum < SAT_MIN) begin
        sat = SAT_MIN[SW-1:0];
      end else begin
        sat = sum[SW-1:0];
      end
    end

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        prod_q <= '0;
        trig_q <= 1'b0;
        out_q  <= '0;
      end else begin
        prod_q        <= data_i[ch].data * scale_i[ch];
        trig_q        <= data_i[ch].trigger;
        out_q.data    <= sat;
        out_q.trigger <= trig_q;
      end
    end

    assign dac_frame_o[ch] = out_q;
  end

  a_out_known: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    !$isunknown(dac_frame_o))
    else $error("DAC frame has unknown bits");

endmodule

/* hw/channel_mux.sv */
/*
 registered source crossbar, each output channel picks one of the
 AWG or triangle samples of any channel
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module channel_mux (
  input  logic                                           ps_clk,
  input  logic                                           arst_n_i,
  input  logic [`TX_CHANNELS-1:0][`TX_MUX_SEL_BITS-1:0] sel_i,
  input  tx_pkg::frame_t                                 awg_i,
  input  tx_pkg::frame_t                                 tri_i,
  output tx_pkg::frame_t                                 mux_o
);

  import tx_pkg::*;

  sample_t [`TX_SOURCES-1:0] src;

  // AWG channels first, then triangle channels
  assign src = {tri_i, awg_i};

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    sample_t out_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        out_q <= '0;
      end else begin
        out_q <= src[sel_i[ch]];
      end
    end

    assign mux_o[ch] = out_q;
  end

endmodule

/* hw/triangle_gen.sv */
/*
 triangle generator: per-channel phase accumulator folded at mid-period,
 trigger on the first sample after each accumulator wrap
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module triangle_gen (
  input  logic                                         ps_clk,
  input  logic                                         arst_n_i,
  input  logic [`TX_CHANNELS-1:0][`TX_PHASE_BITS-1:0] phase_inc_i,
  output tx_pkg::frame_t                               tri_o
);

  import tx_pkg::*;

  localparam int PB = `TX_PHASE_BITS;
  localparam int SW = `TX_SAMPLE_WIDTH;

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    logic [PB-1:0] acc_q;
    logic [PB-1:0] acc_next;
    logic          carry;
    logic          wrap_q;
    logic [SW-1:0] ramp;
    sample_t       out_q;

    assign {carry, acc_next} = {1'b0, acc_q} + {1'b0, phase_inc_i[ch]};

    // msb picks rising or falling half, next bits give the ramp
    assign ramp = acc_q[PB-1] ? ~acc_q[PB-2 -: SW] : acc_q[PB-2 -: SW];

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        acc_q  <= '0;
        wrap_q <= 1'b0;
        out_q  <= '0;
      end else begin
        acc_q         <= acc_next;
        wrap_q        <= carry;
        out_q.trigger <= wrap_q;
        // offset binary to two's complement
        out_q.data    <= {~ramp[SW-1], ramp[SW-2:0]};
      end
    end

    assign tri_o[ch] = out_q;
  end

endmodule

/* hw/awg_player.sv */
/*
 arbitrary waveform player: one sample memory per channel, looped playback
 of a programmable frame length, trigger on the first sample of each frame
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module awg_player (
  input  logic                                             ps_clk,
  input  logic                                             arst_n_i,
  input  logic [`TX_CHANNELS-1:0][`TX_AWG_DEPTH_BITS-1:0] depth_i,
  input  logic                                             mem_we_i,
  input  logic [`TX_CHAN_BITS-1:0]                         mem_chan_i,
  input  logic [`TX_AWG_IDX_BITS-1:0]                      mem_idx_i,
  input  tx_pkg::data_t                                    mem_data_i,
  input  logic                                             start_i,
  input  logic                                             stop_i,
  output tx_pkg::frame_t                                   awg_o
);

  import tx_pkg::*;

  localparam int DB = `TX_AWG_DEPTH_BITS;

  data_t mem [`TX_CHANNELS][`TX_AWG_DEPTH];
  logic  playing_q;

  always_ff @(posedge ps_clk) begin
    if (mem_we_i) begin
      mem[mem_chan_i][mem_idx_i] <= mem_data_i;
    end
  end

  // stop wins over a simultaneous start
  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      playing_q <= 1'b0;
    end else if (stop_i) begin
      playing_q <= 1'b0;
    end else if (start_i) begin
      playing_q <= 1'b1;
    end
  end

  for (genvar ch = 0; ch < `TX_CHANNELS; ch++) begin : g_chan
    logic [DB-1:0] rd_idx_q;
    logic [DB-1:0] cur_idx;
    logic [DB-1:0] last_idx;
    sample_t       out_q;

    // depth 0 plays a single sample, oversized depths are clamped
    always_comb begin
      if (depth_i[ch] == '0) begin
        last_idx = '0;
      end else if (depth_i[ch] > `TX_AWG_DEPTH) begin
        last_idx = DB'(`TX_AWG_DEPTH - 1);
      end else begin
        last_idx = depth_i[ch] - 1'b1;
      end
    end

    // start always restarts the frame
    assign cur_idx = start_i ? '0 : rd_idx_q;

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
        rd_idx_q <= '0;
        out_q    <= '0;
      end else if (stop_i) begin
        rd_idx_q <= '0;
        out_q    <= '0;
      end else if (start_i || playing_q) begin
        out_q.data    <= mem[ch][cur_idx[`TX_AWG_IDX_BITS-1:0]];
        out_q.trigger <= cur_idx == '0;
        rd_idx_q      <= (cur_idx >= last_idx) ? '0 : cur_idx + 1'b1;
      end
    end

    assign awg_o[ch] = out_q;

    a_idx_in_mem: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
      rd_idx_q < `TX_AWG_DEPTH)
      else $error("AWG channel %0d read index %0d past memory end", ch, rd_idx_q);
  end

endmodule

/* hw/tx_config_regs.sv */
/*
 configuration register file: decodes address/data writes into channel
 settings, AWG memory writes and playback start/stop pulses
*/
`timescale 1ns/1ps
`include "tx_consts.svh"

module tx_config_regs (
  input  logic                          ps_clk,
  input  logic                          arst_n_i,
  input  logic                          cfg_we_i,
  input  logic [7:0]                    cfg_addr_i,
  input  tx_pkg::cfg_word_u             cfg_data_i,
  output tx_pkg::cfg_t                  cfg_o,
  output logic                          mem_we_o,
  output logic [`TX_CHAN_BITS-1:0]      mem_chan_o,
  output logic [`TX_AWG_IDX_BITS-1:0]   mem_idx_o,
  output tx_pkg::data_t                 mem_data_o,
  output logic                          awg_start_o,
  output logic                          awg_stop_o
);

  logic [3:0]               addr_ch;
  logic [`TX_CHAN_BITS-1:0] ch_idx;
  logic                     ch_in_range;
  logic                     hit_mux;
  logic                     hit_scale;
  logic                     hit_inc;
  logic                     hit_depth;
  logic                     hit_ctrl;
  logic                     hit_mem;
  logic                     addr_valid;

  // low nibble selects the channel in the per-channel ranges
  assign addr_ch     = cfg_addr_i[3:0];
  assign ch_idx      = cfg_addr_i[`TX_CHAN_BITS-1:0];
  assign ch_in_range = addr_ch < `TX_CHANNELS;

  assign hit_mux   = ({cfg_addr_i[7:4], 4'h0} == `TX_ADDR_MUX_SEL) && ch_in_range;
  assign hit_scale = ({cfg_addr_i[7:4], 4'h0} == `TX_ADDR_SCALE_OFFSET) && ch_in_range;
  assign hit_inc   = ({cfg_addr_i[7:4], 4'h0} == `TX_ADDR_TRI_INC) && ch_in_range;
  assign hit_depth = ({cfg_addr_i[7:4], 4'h0} == `TX_ADDR_AWG_DEPTH) && ch_in_range;
  assign hit_ctrl  = cfg_addr_i == `TX_ADDR_AWG_CTRL;
  assign hit_mem   = (cfg_addr_i >= `TX_ADDR_AWG_MEM) &&
                     (cfg_addr_i < `TX_ADDR_AWG_MEM + `TX_CHANNELS * `TX_AWG_DEPTH);

  assign addr_valid = hit_mux | hit_scale | hit_inc | hit_depth | hit_ctrl | hit_mem;

  always_ff @(posedge ps_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_o       <= '0;
      mem_we_o    <= 1'b0;
      awg_start_o <= 1'b0;
      awg_stop_o  <= 1'b0;
    end else begin
      mem_we_o    <= cfg_we_i && hit_mem;
      // ctrl word: bit 0 start, bit 1 stop
      awg_start_o <= cfg_we_i && hit_ctrl && cfg_data_i[0];
      awg_stop_o  <= cfg_we_i && hit_ctrl && cfg_data_i[1];
      if (cfg_we_i) begin
        if (hit_mux) begin
          cfg_o.mux_sel[ch_idx] <= cfg_data_i.mux.sel;
        end
        if (hit_scale) begin
          cfg_o.scale[ch_idx]  <= cfg_data_i.scale_offset.scale;
          cfg_o.offset[ch_idx] <= cfg_data_i.scale_offset.offset;
        end
        if (hit_inc) begin
          cfg_o.tri_inc[ch_idx] <= cfg_data_i.phase_inc;
        end
        if (hit_depth) begin
          cfg_o.awg_depth[ch_idx] <= cfg_data_i[`TX_AWG_DEPTH_BITS-1:0];
        end
      end
    end
  end

  // memory address splits into channel and sample index
  always_ff @(posedge ps_clk) begin
    if (cfg_we_i && hit_mem) begin
      mem_chan_o <= cfg_addr_i[`TX_AWG_IDX_BITS +: `TX_CHAN_BITS];
      mem_idx_o  <= cfg_addr_i[`TX_AWG_IDX_BITS-1:0];
      mem_data_o <= cfg_data_i.awg.sample;
    end
  end

  a_addr_mapped: assert property (@(posedge ps_clk) disable iff (!arst_n_i)
    cfg_we_i |-> addr_valid)
    else $error("configuration write to unmapped address 0x%02h", cfg_addr_i);

endmodule

/* hw/tx_pkg.sv */
/*
 transmit path types: samples, channel frames and configuration words
*/
`include "tx_consts.svh"

package tx_pkg;

  typedef logic signed [`TX_SAMPLE_WIDTH-1:0] data_t;
  typedef logic signed [`TX_SCALE_WIDTH-1:0]  scale_t;
  typedef logic signed [`TX_OFFSET_WIDTH-1:0] offset_t;

  typedef struct packed {
    logic  trigger;
    data_t data;
  } sample_t;

  // one sample per channel, channel 0 in the low bits
  typedef sample_t [`TX_CHANNELS-1:0] frame_t;

  // write data, viewed according to the address range it targets
  typedef union packed {
    logic [`TX_PHASE_BITS-1:0] phase_inc;
    struct packed {
      scale_t  scale;
      offset_t offset;
    } scale_offset;
    struct packed {
      logic [31-`TX_SAMPLE_WIDTH:0] unused;
      data_t                        sample;
    } awg;
    struct packed {
      logic [31-`TX_MUX_SEL_BITS:0]   unused;
      logic [`TX_MUX_SEL_BITS-1:0]    sel;
    } mux;
  } cfg_word_u;

  typedef struct packed {
    logic [`TX_CHANNELS-1:0][`TX_MUX_SEL_BITS-1:0]   mux_sel;
    scale_t [`TX_CHANNELS-1:0]                        scale;
    offset_t [`TX_CHANNELS-1:0]                       offset;
    logic [`TX_CHANNELS-1:0][`TX_PHASE_BITS-1:0]     tri_inc;
    logic [`TX_CHANNELS-1:0][`TX_AWG_DEPTH_BITS-1:0] awg_depth;
  } cfg_t;

endpackage

/* hw/tx_consts.svh */
/*
 transmit path constants: channel count, widths and register address map
*/
`ifndef TX_CONSTS_SVH
`define TX_CONSTS_SVH

`define TX_CHANNELS         2
`define TX_CHAN_BITS        1
`define TX_SOURCES          (2 * `TX_CHANNELS)
`define TX_MUX_SEL_BITS     2
`define TX_SAMPLE_WIDTH     16
`define TX_AWG_DEPTH        16
`define TX_AWG_IDX_BITS     4
`define TX_AWG_DEPTH_BITS   5
`define TX_PHASE_BITS       32

// Q2.16 scale, signed offset in DAC LSBs
`define TX_SCALE_WIDTH      18
`define TX_SCALE_FRAC_BITS  16
`define TX_OFFSET_WIDTH     14

`define TX_ADDR_MUX_SEL       8'h00
`define TX_ADDR_SCALE_OFFSET  8'h10
`define TX_ADDR_TRI_INC       8'h20
`define TX_ADDR_AWG_DEPTH     8'h30
`define TX_ADDR_AWG_CTRL      8'h40
`define TX_ADDR_AWG_MEM       8'h80

`endif
